//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_isa_pkg::alu_op_e op,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    output logic [31:0]         y,
    output logic                eq
);
    logic [4:0] shamt;

    assign shamt = b[4:0];
    assign eq    = (a == b); // beq and bne both use this

    always_comb begin
        case (op)
            rv_isa_pkg::ADD:    y = a + b;
            rv_isa_pkg::SUB:    y = a - b;
            rv_isa_pkg::AND:    y = a & b;
            rv_isa_pkg::OR:     y = a | b;
            rv_isa_pkg::XOR:    y = a ^ b;
            rv_isa_pkg::SLT:    y = {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::SLL:    y = a << shamt;
            rv_isa_pkg::SRL:    y = a >> shamt;
            rv_isa_pkg::PASS_B: y = b;
            default:            y = '0;
        endcase
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    input  logic                 we,
    output logic [31:0]          rdata,
    output logic                 tx_push,
    output io_map_pkg::io_byte_t tx_byte
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0] mem [DMEM_WORDS];
    logic [AW-1:0] index;
    logic          io_hit;

    assign index  = addr[AW+1:2];
    assign io_hit = (addr[31:3] == io_map_pkg::IO_TX_ADDR[31:3]); // Both port words

    // Stores to the port never reach the array
    always_ff @(posedge clk) begin
        if (we && !io_hit)
            mem[index] <= wdata;
    end

    assign rdata        = mem[index];
    assign tx_push      = we && io_hit;
    assign tx_byte.data = wdata[7:0];
    assign tx_byte.last = addr[2]; // IO_TX_ADDR+4 closes a message

    store_aligned: assert property (
        @(posedge clk) disable iff (reset) we |-> addr[1:0] == 2'b00
    ) else $error("data_mem: misaligned store to %h", addr);

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [31:0]           instr,
    output rv_isa_pkg::decoded_t  dec
);
    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::alu_op_e arith_op;
    logic [2:0]          funct3;
    logic                legal;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Shared by register and immediate arithmetic
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv_isa_pkg::OP_REG && instr[30]) ?
                                rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            3'b001:  arith_op = rv_isa_pkg::SLL;
            3'b010:  arith_op = rv_isa_pkg::SLT;
            3'b100:  arith_op = rv_isa_pkg::XOR;
            3'b101:  arith_op = rv_isa_pkg::SRL;
            3'b110:  arith_op = rv_isa_pkg::OR;
            3'b111:  arith_op = rv_isa_pkg::AND;
            default: arith_op = rv_isa_pkg::ADD;
        endcase
    end

    always_comb begin
        dec     = '0;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        legal   = 1'b1;
        case (opcode)
            rv_isa_pkg::OP_LUI: begin
                dec.imm       = {instr[31:12], 12'b0};
                dec.alu_op    = rv_isa_pkg::PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.alu_op    = arith_op;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OP_REG: begin
                dec.alu_op    = arith_op;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            rv_isa_pkg::OP_STORE: begin
                dec.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                dec.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};
                dec.alu_op    = rv_isa_pkg::SUB;
                dec.branch    = 1'b1;
                dec.branch_ne = funct3[0];
            end
            rv_isa_pkg::OP_JAL: begin
                dec.imm       = {{11{instr[31]}}, instr[31], instr[19:12],
                                 instr[20], instr[30:21], 1'b0};
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
                dec.link      = 1'b1;
            end
            rv_isa_pkg::OP_JALR: begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
                dec.jalr      = 1'b1;
                dec.link      = 1'b1;
            end
            default: legal = 1'b0; // Bubble
        endcase
    end

    // Squashed or unloaded slots may hold X, only real words are checked
    always_comb begin
        assert #0 (legal || $isunknown(instr))
            else $warning("decoder: unsupported opcode %b", instr[6:0]);
    end

endmodule

//--- hdl/io_map_pkg.sv
package io_map_pkg;

    // Byte output port, data word at +0, last byte of a message at +4
    localparam logic [31:0] IO_TX_ADDR = 32'h0000_1000;

    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } io_byte_t;

endpackage

//--- hdl/io_tx_buffer.sv
`timescale 1ns/1ps

module io_tx_buffer #(
    parameter int IO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  io_map_pkg::io_byte_t push_byte,
    output logic                 full,
    output logic                 io_req,
    input  logic                 io_ack,
    output io_map_pkg::io_byte_t io_data
);
    localparam int PW = $clog2(IO_DEPTH);

    typedef enum logic {HS_SEND, HS_RELEASE} hs_state_e;

    io_map_pkg::io_byte_t fifo [IO_DEPTH];
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        empty;
    hs_state_e   state;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr == {~rd_ptr[PW], rd_ptr[PW-1:0]});

    always_ff @(posedge clk) begin
        if (push)
            fifo[wr_ptr[PW-1:0]] <= push_byte;
    end

    // ############################
    // Four-phase handshake

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            io_req <= 1'b0;
            state  <= HS_SEND;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            case (state)
                HS_SEND: begin
                    if (!io_req && !empty && !io_ack) begin
                        io_data <= fifo[rd_ptr[PW-1:0]]; // Head leaves the FIFO here
                        rd_ptr  <= rd_ptr + 1'b1;
                        io_req  <= 1'b1;
                    end else if (io_req && io_ack) begin
                        io_req <= 1'b0;
                        state  <= HS_RELEASE;
                    end
                end
                HS_RELEASE: if (!io_ack) state <= HS_SEND; // Wait for ack low
                default:    state <= HS_SEND;
            endcase
        end
    end

    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) !(push && full)
    ) else $error("io_tx_buffer: push while full");

    // The receiver answers only a pending request
    ack_only_with_req: assert property (
        @(posedge clk) disable iff (reset) $rose(io_ack) |-> io_req
    ) else $error("io_tx_buffer: ack rose without req");

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we)
            regs[wa] <= wd;
    end

    // x0 reads zero and a same-cycle write is seen by the reader
    always_comb begin
        if (rs1 == 5'd0)
            rd1 = '0;
        else if (we && wa == rs1)
            rd1 = wd;
        else
            rd1 = regs[rs1];
        if (rs2 == 5'd0)
            rd2 = '0;
        else if (we && wa == rs2)
            rd2 = wd;
        else
            rd2 = regs[rs2];
    end

    // The core filters rd == 0 before the write port
    x0_never_written: assert property (@(posedge clk) we |-> wa != 5'd0)
        else $error("regfile: write to x0");

endmodule

//--- hdl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256,
    parameter int IO_DEPTH   = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prog_we,
    input  logic [7:0]           prog_addr,
    input  logic [31:0]          prog_data,
    output logic                 io_req,
    output io_map_pkg::io_byte_t io_data,
    input  logic                 io_ack
);
    localparam int IW = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] instr_q;
    logic [31:0] d_pc;
    logic        d_valid;
    rv_isa_pkg::decoded_t dec;
    logic [31:0] rf_rd1, rf_rd2;

    rv_isa_pkg::decoded_t s2_dec;
    logic        s2_valid;
    logic [31:0] s2_pc, s2_rd1, s2_rd2;
    logic [31:0] rs1_val, rs2_val, op_a, op_b, alu_y;
    logic        eq, take;
    logic [31:0] target;

    rv_isa_pkg::decoded_t s3_dec;
    logic        s3_valid;
    logic [31:0] s3_alu_y, s3_store, s3_pc4;
    logic [31:0] dm_rdata, wb_data;
    logic        rf_we, tx_push, tx_full, stall;
    io_map_pkg::io_byte_t tx_byte;

    // ############################
    // Fetch and decode

    always_ff @(posedge clk) begin
        if (reset && prog_we)
            imem[prog_addr[IW-1:0]] <= prog_data;
        if (!stall)
            instr_q <= imem[pc[IW+1:2]]; // Synchronous read takes one cycle
    end

    decoder u_decoder (.instr(instr_q), .dec(dec));

    // Read in decode, so a write from stage three lands through the bypass
    regfile u_regfile (
        .clk(clk), .rs1(dec.rs1), .rs2(dec.rs2), .rd1(rf_rd1), .rd2(rf_rd2),
        .we(rf_we), .wa(s3_dec.rd), .wd(wb_data)
    );

    // ############################
    // Execute and branch resolve

    always_comb begin
        rs1_val = s2_rd1;
        rs2_val = s2_rd2;
        if (rf_we && s3_dec.rd == s2_dec.rs1) rs1_val = wb_data; // Forward from stage three
        if (rf_we && s3_dec.rd == s2_dec.rs2) rs2_val = wb_data;
    end

    assign op_a = s2_dec.use_pc ? s2_pc : rs1_val;
    assign op_b = s2_dec.use_imm ? s2_dec.imm : rs2_val;

    alu u_alu (.op(s2_dec.alu_op), .a(op_a), .b(op_b), .y(alu_y), .eq(eq));

    assign take   = s2_valid && (s2_dec.jump || (s2_dec.branch && (eq ^ s2_dec.branch_ne)));
    assign target = !s2_dec.jump ? s2_pc + s2_dec.imm : // Branch target adder
                    s2_dec.jalr  ? {alu_y[31:1], 1'b0} : alu_y;

    // ############################
    // Memory and writeback

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_data_mem (
        .clk(clk), .reset(reset), .addr(s3_alu_y), .wdata(s3_store),
        .we(s3_valid && s3_dec.mem_write), .rdata(dm_rdata),
        .tx_push(tx_push), .tx_byte(tx_byte)
    );

    io_tx_buffer #(.IO_DEPTH(IO_DEPTH)) u_io_tx_buffer (
        .clk(clk), .reset(reset), .push(tx_push && !tx_full), .push_byte(tx_byte),
        .full(tx_full), .io_req(io_req), .io_ack(io_ack), .io_data(io_data)
    );

    assign stall = tx_push && tx_full; // Port store waits for room
    assign rf_we = s3_valid && s3_dec.reg_write && s3_dec.rd != 5'd0;

    always_comb begin
        if (s3_dec.link)
            wb_data = s3_pc4;
        else if (s3_dec.mem_read)
            wb_data = dm_rdata;
        else
            wb_data = s3_alu_y;
    end

    // ############################
    // Pipeline registers

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            d_valid  <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= take ? target : pc + 32'd4;
            d_valid  <= !take;             // Squash the word being fetched
            s2_valid <= d_valid && !take;  // and the one being decoded
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pc     <= pc;
            s2_dec   <= dec;
            s2_pc    <= d_pc;
            s2_rd1   <= rf_rd1;
            s2_rd2   <= rf_rd2;
            s3_dec   <= s2_dec;
            s3_alu_y <= alu_y;
            s3_store <= rs2_val;
            s3_pc4   <= s2_pc + 32'd4;
        end
    end

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLL    = 4'd6,
        SRL    = 4'd7,
        PASS_B = 4'd8
    } alu_op_e;

    // Everything stage two and three need to know about one instruction
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        use_pc;    // Operand a is the PC
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne; // bne instead of beq
        logic        jump;
        logic        jalr;
        logic        link;      // Write back PC+4
    } decoded_t;

endpackage

//--- tb.f
hdl/rv_isa_pkg.sv
hdl/io_map_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/io_tx_buffer.sv
hdl/riscv_core.sv
tests/io_checker.sv
tests/tb_top.sv

//--- tests/core_stim.txt
// Word 0 is the program length, then the program words, four per line.
// After them the expected byte count and the bytes as {last, data[7:0]}.
00000042
000012B7 00500093 0012A023 12345137  // 0: lui x5,1; addi x1,5; sw x1; lui x2,0x12345
00C00213 004151B3 0032A023 FFD00313  // 4: addi x4,12; srl x3,x2,x4; sw x3; addi x6,-3
001303B3 0072A023 40608433 0082A023  // 8: add x7,x6,x1; sw x7; sub x8,x1,x6; sw x8
06C00513 03A00593 00B57633 00C2A023  // 12: addi x10,0x6C; addi x11,0x3A; and x12; sw
00B56633 00C2A023 00B54633 00C2A023  // 16: or x12; sw; xor x12; sw
00132633 00C2A023 00300693 00D59633  // 20: slt x12,x6,x1; sw; addi x13,3; sll x12,x11,x13
00C2A023 00100713 00E70733 00E70733  // 24: sw; addi x14,1; add x14,x14,x14 twice
00170733 00E2A023 01070793 00700813  // 28: add x14,x14,x1; sw; addi x15,x14,0x10; addi x16,7
010788B3 01178933 0122A023 00108663  // 32: add x17,x15,x16; add x18,x15,x17; sw; beq +12
0062A023 0062A023 00609663 0062A023  // 36: shadow, shadow; bne x1,x6,+12; shadow
0062A023 00608463 03300993 0132A023  // 40: shadow; beq x1,x6,+8 not taken; addi x19; sw
00C00A6F 0062A023 0062A023 0142A023  // 44: jal x20,+12; shadow, shadow; sw x20
0D000A93 000A8B67 0062A023 0062A023  // 48: addi x21,0xD0; jalr x22,0(x21); shadow, shadow
0162A023 A1B2CBB7 3D4B8B93 05702023  // 52: sw x22; lui x23; addi x23,0x3D4; sw x23,64(x0)
04002C03 0182A023 00800C93 019C5C33  // 56: lw x24,64(x0); sw x24; addi x25,8; srl x24
0182A023 019C5C33 0182A023 019C5C33  // 60: sw; srl; sw; srl
0182A223 0000006F                    // 64: sw x24,4(x5) ends the message; jal x0,0
00000012
005 045 002 008 028 07E 056 001 0D0  // ALU results
009 039 033 0B4 0C8 0D4 0C3 0B2 1A1  // Forwarding, branches, links, loaded word

//--- tests/io_checker.sv
`timescale 1ns/1ps

module io_checker #(
    parameter int MAX_BYTES = 64
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      io_req,
    input  logic                      io_ack,
    input  io_map_pkg::io_byte_t      io_data,
    input  logic [MAX_BYTES-1:0][8:0] exp_bytes,
    input  int                        exp_count,
    output int                        compared,
    output int                        mismatches,
    output int                        errors,
    output logic                      all_seen
);
    logic                 req_q;
    io_map_pkg::io_byte_t data_q;
    int                   received;

    assign all_seen = (exp_count > 0) && (received >= exp_count);

    // Sampled at the edge, before the DUT outputs move
    always @(posedge clk) begin
        if (reset) begin
            req_q      <= 1'b0;
            received   <= 0;
            compared   <= 0;
            mismatches <= 0;
            errors     <= 0;
        end else begin
            req_q  <= io_req;
            data_q <= io_data;
            if (io_req && !req_q) begin // New byte offered
                received <= received + 1;
                if (io_ack) begin
                    errors <= errors + 1;
                    $display("Handshake error at %0t: req rose while ack was high", $time);
                end else if (received >= exp_count) begin
                    errors <= errors + 1;
                    $display("Unexpected byte %h at %0t after the last expected one",
                             io_data, $time);
                end
                if (received < exp_count) begin
                    compared <= compared + 1;
                    if (io_data !== exp_bytes[received]) begin
                        mismatches <= mismatches + 1;
                        $display("Mismatch at %0t: byte %0d is %h, expected %h",
                                 $time, received, io_data, exp_bytes[received]);
                    end
                end
            end else if (io_req && req_q && io_data !== data_q) begin
                errors <= errors + 1;
                $display("Handshake error at %0t: data changed while req was high", $time);
            end
        end
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    localparam int MAX_BYTES  = 64;
    localparam int STIM_WORDS = 128;
    localparam int RUN_LIMIT  = 20000; // Cycles allowed for the whole message

    logic                 clk       = 1'b0;
    logic                 reset     = 1'b1;
    logic                 prog_we   = 1'b0;
    logic [7:0]           prog_addr = '0;
    logic [31:0]          prog_data = '0;
    logic                 io_ack    = 1'b0;
    logic                 io_req;
    io_map_pkg::io_byte_t io_data;

    logic [31:0]               stim [STIM_WORDS];
    logic [MAX_BYTES-1:0][8:0] exp_bytes = '0;
    int                        exp_count = 0;
    int                        prog_count = 0;
    int                        tb_errors = 0;
    int                        compared;
    int                        mismatches;
    int                        chk_errors;
    logic                      all_seen;

    always #4 clk = ~clk;

    riscv_core #(
        .IMEM_WORDS(256),
        .DMEM_WORDS(256),
        .IO_DEPTH(4)
    ) UUT (
        .clk(clk), .reset(reset),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .io_req(io_req), .io_data(io_data), .io_ack(io_ack)
    );

    io_checker #(.MAX_BYTES(MAX_BYTES)) u_io_checker (
        .clk(clk), .reset(reset), .io_req(io_req), .io_ack(io_ack), .io_data(io_data),
        .exp_bytes(exp_bytes), .exp_count(exp_count),
        .compared(compared), .mismatches(mismatches), .errors(chk_errors),
        .all_seen(all_seen)
    );

    // Gives up after limit cycles
    task automatic wait_for_req(input logic level, input int limit, output logic ok);
        int cycles;
        cycles = 0;
        while (io_req !== level && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        ok = (io_req === level);
    endtask

    // ############################
    // Ack responder

    initial begin : ack_responder
        int   delay;
        int   cycles;
        logic ok;
        delay  = $urandom(32'h6530225d);
        cycles = 0;
        while (reset && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        for (int n = 0; n < exp_count; n++) begin
            wait_for_req(1'b1, 2000, ok);
            if (!ok) begin
                tb_errors++;
                $display("Handshake stuck at %0t: no req for byte %0d", $time, n);
                break;
            end
            delay = $urandom_range(0, 6);
            if ($urandom_range(0, 7) == 0)
                delay = 20; // Long stall, the FIFO fills up
            repeat (delay) @(posedge clk);
            io_ack <= 1'b1;
            wait_for_req(1'b0, 50, ok);
            if (!ok) begin
                tb_errors++;
                $display("Handshake stuck at %0t: req stayed high after ack", $time);
                break;
            end
            delay = $urandom_range(0, 6);
            repeat (delay) @(posedge clk);
            io_ack <= 1'b0;
        end
    end

    // ############################
    // Program load and run

    initial begin : main_sequence
        int cycles;
        $readmemh("tests/core_stim.txt", stim);
        if ($isunknown(stim[0])) begin
            tb_errors++;
            $display("Could not read the program from tests/core_stim.txt");
        end else begin
            prog_count = stim[0];
            exp_count  = stim[prog_count + 1];
            for (int i = 0; i < exp_count; i++)
                exp_bytes[i] = stim[prog_count + 2 + i][8:0];
        end

        // Reset stays high through the load and three cycles more
        for (int i = 0; i < prog_count; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= stim[i + 1];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!all_seen && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!all_seen) begin
            tb_errors++;
            $display("Timeout: only %0d of %0d expected bytes arrived", compared, exp_count);
        end
        repeat (100) @(posedge clk); // A stray byte from a squashed store would show here

        $display("Bytes compared: %0d of %0d, mismatches: %0d, other errors: %0d",
                 compared, exp_count, mismatches, chk_errors + tb_errors);
        if (all_seen && mismatches == 0 && chk_errors == 0 && tb_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
